/* ctrl_pkg.sv */
// encodings and strobe bundle shared by the core control FSM
// referenced with ctrl_pkg:: scoped names from the FSM, the top level and the testbench
package ctrl_pkg;

  // fetch-stage PC source select
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_ERET      = 3'd4,
    PC_EXCEPTION = 3'd5
  } pc_mux_e;

  // jump class of the instruction sitting in decode
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } jump_kind_e;

  // control FSM states
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // exception controller strobes, single-cycle pulses
  typedef struct packed {
    logic ack;
    logic irq_ack;
    logic save_if;
    logic save_id;
    logic restore_mret;
    logic restore_uret;
  } exc_ctrl_t;

endpackage

/* hazard_pkg.sv */
// types for stall detection and operand forwarding in the ID stage
// referenced with hazard_pkg:: scoped names by the hazard and forwarding units
package hazard_pkg;

  // operand source seen by the ID stage operand muxes
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fwd_src_e;

  // destination register of a stage equals a source register in ID
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic ex_c;
    logic wb_a;
    logic wb_b;
    logic wb_c;
    logic alu_a;
    logic alu_b;
    logic alu_c;
  } reg_match_t;

  // register file write enables of the later stages
  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic alu_we_fw;
  } wr_en_t;

  // stall causes
  typedef struct packed {
    logic load;
    logic jr;
    logic csr;
    logic misaligned;
  } stall_t;

  // forwarding mux selects for operands a, b and c
  typedef struct packed {
    fwd_src_e a;
    fwd_src_e b;
    fwd_src_e c;
  } fwd_sel_t;

endpackage

/* ctrl_fsm.sv */
// main control FSM: boot, sleep, decode, pipeline flush and exception entry
// drives fetch requests, PC redirection, halts and exception strobes
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   id_ready_i,
  input  logic                   ex_valid_i,
  input  logic                   branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e   jump_in_dec_i,
  input  logic                   mret_insn_i,
  input  logic                   uret_insn_i,
  input  logic                   pipe_flush_i,
  input  logic                   int_req_i,
  input  logic                   ext_req_i,
  input  logic                   jr_stall_i,
  output logic                   ctrl_busy_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output logic                   pc_set_o,
  output ctrl_pkg::pc_mux_e      pc_mux_o,
  output ctrl_pkg::exc_ctrl_t    exc_o,
  output logic                   enable_exceptions_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;

  // one-shot guard so a jump sets the PC once while ID is stalled
  logic jump_done_q, jump_done_d;
  logic exc_req;
  logic uncond_jump;

  assign exc_req     = int_req_i | ext_req_i;
  assign uncond_jump = (jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
                       (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    // defaults, busy and fetching
    state_d             = state_q;
    jump_done_d         = jump_done_q;
    ctrl_busy_o         = 1'b1;
    instr_req_o         = 1'b1;
    is_decoding_o       = 1'b0;
    pc_set_o            = 1'b0;
    pc_mux_o            = ctrl_pkg::PC_BOOT;
    exc_o               = '0;
    enable_exceptions_o = 1'b0;
    halt_if_o           = 1'b0;
    halt_id_o           = 1'b0;

    case (state_q)
      // idle after reset until fetch is enabled
      ctrl_pkg::RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      // load the boot address into the fetch PC, one cycle
      ctrl_pkg::BOOT_SET: begin
        pc_mux_o = ctrl_pkg::PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // core stopped, wake on fetch enable or any request
      ctrl_pkg::SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      ctrl_pkg::FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // request pending from sleep, enter the handler straight away
        if (exc_req) begin
          pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_o.ack     = 1'b1;
          exc_o.irq_ack = ext_req_i;
          exc_o.save_if = 1'b1;
        end
      end

      ctrl_pkg::DECODE: begin
        // only decode when no taken branch sits in EX
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (ext_req_i) begin
            // external interrupt, drain the pipeline first
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end else begin
            if (uncond_jump) begin
              // target known in ID, jalr waits for its operand
              pc_mux_o = ctrl_pkg::PC_JUMP;
              if (!jr_stall_i && !jump_done_q) begin
                pc_set_o    = 1'b1;
                jump_done_d = 1'b1;
              end
            end else if (mret_insn_i) begin
              pc_mux_o           = ctrl_pkg::PC_ERET;
              exc_o.restore_mret = 1'b1;
              if (!jump_done_q) begin
                pc_set_o    = 1'b1;
                jump_done_d = 1'b1;
              end
            end else if (uret_insn_i) begin
              pc_mux_o           = ctrl_pkg::PC_ERET;
              exc_o.restore_uret = 1'b1;
              if (!jump_done_q) begin
                pc_set_o    = 1'b1;
                jump_done_d = 1'b1;
              end
            end else if (int_req_i) begin
              // ecall or illegal instruction
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = ctrl_pkg::FLUSH_EX;
            end

            // wfi, or a return that should go back to sleep
            if (pipe_flush_i || ((mret_insn_i || uret_insn_i) && !fetch_enable_i)) begin
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = ctrl_pkg::FLUSH_EX;
            end
          end
        end

        // taken branch in EX wins, the ID instruction is dropped
        if (branch_taken_ex_i) begin
          pc_mux_o      = ctrl_pkg::PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      // hold ID until EX has retired its instruction
      ctrl_pkg::FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = ctrl_pkg::FLUSH_WB;
        end
      end

      // pipeline empty, enter handler, resume or sleep
      ctrl_pkg::FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (!fetch_enable_i) begin
          state_d = ctrl_pkg::SLEEP;
        end else begin
          state_d             = ctrl_pkg::DECODE;
          // lets int_req_i rise for ecall and illegal instructions
          enable_exceptions_o = 1'b1;
          if (int_req_i) begin
            pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_o.ack     = 1'b1;
            exc_o.save_id = 1'b1;
          end else if (ext_req_i) begin
            pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_o.ack     = 1'b1;
            exc_o.irq_ack = 1'b1;
            exc_o.save_id = 1'b1;
          end else begin
            halt_if_o = 1'b0;
          end
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and jump guard registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // guard drops once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

/* hazard_unit.sv */
// ID stage stall detection and register write-enable deassert
`timescale 1ns/1ps

module hazard_unit (
  input  logic                    is_decoding_i,
  input  logic                    illegal_insn_i,
  input  logic                    data_req_ex_i,
  input  logic                    data_misaligned_i,
  input  logic                    csr_busy_i,
  input  logic                    csr_access_id_i,
  input  ctrl_pkg::jump_kind_e    jump_in_dec_i,
  input  hazard_pkg::wr_en_t      wr_en_i,
  input  hazard_pkg::reg_match_t  match_i,
  output hazard_pkg::stall_t      stall_o,
  output logic                    deassert_we_o
);

  logic ex_hit_any;
  logic jr_dep;

  // any source register produced by the instruction in EX
  assign ex_hit_any = match_i.ex_a | match_i.ex_b | match_i.ex_c;

  // jalr target register still in flight somewhere downstream
  assign jr_dep = (wr_en_i.we_wb     & match_i.wb_a) |
                  (wr_en_i.we_ex     & match_i.ex_a) |
                  (wr_en_i.alu_we_fw & match_i.alu_a);

  always_comb begin
    stall_o = '0;

    // load-use, loaded value not ready until WB
    stall_o.load = data_req_ex_i & wr_en_i.we_ex & ex_hit_any;

    // CSR being written in EX while ID reads a CSR
    stall_o.csr = csr_busy_i & csr_access_id_i;

    // jump register must come from the register file
    stall_o.jr = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR) & jr_dep;

    // second half of a misaligned access occupies EX
    stall_o.misaligned = data_misaligned_i;
  end

  // no register write for squashed, illegal or stalled instructions
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i |
                         stall_o.load | stall_o.csr | stall_o.jr;

endmodule

/* fwd_unit.sv */
// operand forwarding mux selects for the ID stage operands a, b and c
`timescale 1ns/1ps

module fwd_unit (
  input  hazard_pkg::wr_en_t      wr_en_i,
  input  hazard_pkg::reg_match_t  match_i,
  input  logic                    data_misaligned_i,
  input  logic                    mult_multicycle_i,
  output hazard_pkg::fwd_sel_t    fwd_sel_o
);

  // per-operand priority, newest result wins
  function automatic hazard_pkg::fwd_src_e pick_src(
    input logic wb_hit,
    input logic alu_hit
  );
    hazard_pkg::fwd_src_e src;
    src = hazard_pkg::SEL_REGFILE;
    if (wb_hit) begin
      src = hazard_pkg::SEL_FW_WB;
    end
    if (alu_hit) begin
      src = hazard_pkg::SEL_FW_EX;
    end
    return src;
  endfunction

  always_comb begin
    fwd_sel_o.a = pick_src(wr_en_i.we_wb & match_i.wb_a,
                           wr_en_i.alu_we_fw & match_i.alu_a);
    fwd_sel_o.b = pick_src(wr_en_i.we_wb & match_i.wb_b,
                           wr_en_i.alu_we_fw & match_i.alu_b);
    fwd_sel_o.c = pick_src(wr_en_i.we_wb & match_i.wb_c,
                           wr_en_i.alu_we_fw & match_i.alu_c);

    // misaligned access reuses the address from EX
    if (data_misaligned_i) begin
      fwd_sel_o.a = hazard_pkg::SEL_FW_EX;
      fwd_sel_o.b = hazard_pkg::SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps its partial result on operand c
      fwd_sel_o.c = hazard_pkg::SEL_FW_EX;
    end
  end

endmodule

/* core_ctrl.sv */
// core controller top: control FSM, hazard unit and forwarding unit
`timescale 1ns/1ps

module core_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  logic                    id_ready_i,
  input  logic                    ex_valid_i,
  input  logic                    branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e    jump_in_dec_i,
  input  logic                    mret_insn_i,
  input  logic                    uret_insn_i,
  input  logic                    pipe_flush_i,
  input  logic                    int_req_i,
  input  logic                    ext_req_i,
  input  logic                    illegal_insn_i,
  input  logic                    data_req_ex_i,
  input  logic                    data_misaligned_i,
  input  logic                    csr_busy_i,
  input  logic                    csr_access_id_i,
  input  logic                    mult_multicycle_i,
  input  hazard_pkg::wr_en_t      wr_en_i,
  input  hazard_pkg::reg_match_t  match_i,
  output logic                    ctrl_busy_o,
  output logic                    is_decoding_o,
  output logic                    instr_req_o,
  output logic                    pc_set_o,
  output ctrl_pkg::pc_mux_e       pc_mux_o,
  output ctrl_pkg::exc_ctrl_t     exc_o,
  output logic                    enable_exceptions_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o,
  output logic                    deassert_we_o,
  output hazard_pkg::stall_t      stall_o,
  output hazard_pkg::fwd_sel_t    fwd_sel_o
);

  ctrl_fsm u_fsm (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .id_ready_i          (id_ready_i),
    .ex_valid_i          (ex_valid_i),
    .branch_taken_ex_i   (branch_taken_ex_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .mret_insn_i         (mret_insn_i),
    .uret_insn_i         (uret_insn_i),
    .pipe_flush_i        (pipe_flush_i),
    .int_req_i           (int_req_i),
    .ext_req_i           (ext_req_i),
    // jr stall holds back the jump, no path back into the hazard unit
    .jr_stall_i          (stall_o.jr),
    .ctrl_busy_o         (ctrl_busy_o),
    .is_decoding_o       (is_decoding_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_o               (exc_o),
    .enable_exceptions_o (enable_exceptions_o),
    .halt_if_o           (halt_if_o),
    .halt_id_o           (halt_id_o)
  );

  hazard_unit u_hazard (
    .is_decoding_i     (is_decoding_o),
    .illegal_insn_i    (illegal_insn_i),
    .data_req_ex_i     (data_req_ex_i),
    .data_misaligned_i (data_misaligned_i),
    .csr_busy_i        (csr_busy_i),
    .csr_access_id_i   (csr_access_id_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .wr_en_i           (wr_en_i),
    .match_i           (match_i),
    .stall_o           (stall_o),
    .deassert_we_o     (deassert_we_o)
  );

  fwd_unit u_fwd (
    .wr_en_i           (wr_en_i),
    .match_i           (match_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_sel_o         (fwd_sel_o)
  );

endmodule

/* tb_core_ctrl.sv */
// self-checking testbench for the core controller, directed FSM tests plus random
// hazard and forwarding cycles checked against reference models of the control rules
`timescale 1ns/1ps

module tb_core_ctrl;

  localparam int HAZ_CYCLES  = 500;
  localparam int FWD_CYCLES  = 500;
  localparam int DIR_CYCLES  = 200;
  // twice the expected length of all tests together
  localparam int CYCLE_LIMIT = 2 * (HAZ_CYCLES + FWD_CYCLES + DIR_CYCLES);

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i;
  logic branch_taken_ex_i, mret_insn_i, uret_insn_i, pipe_flush_i;
  logic int_req_i, ext_req_i, illegal_insn_i, data_req_ex_i;
  logic data_misaligned_i, csr_busy_i, csr_access_id_i, mult_multicycle_i;
  ctrl_pkg::jump_kind_e   jump_in_dec_i;
  hazard_pkg::wr_en_t     wr_en_i;
  hazard_pkg::reg_match_t match_i;
  logic ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o;
  logic enable_exceptions_o, halt_if_o, halt_id_o, deassert_we_o;
  ctrl_pkg::pc_mux_e      pc_mux_o;
  ctrl_pkg::exc_ctrl_t    exc_o;
  hazard_pkg::stall_t     stall_o;
  hazard_pkg::fwd_sel_t   fwd_sel_o;

  int seed;
  int cycles = 0;
  int dir_errs = 0;
  int mon_errs = 0;
  int tests_run = 0;
  int tests_bad = 0;
  // 0 off, 1 hazard outputs, 2 forwarding selects
  int chk_mode = 0;
  ctrl_pkg::ctrl_state_e model_st = ctrl_pkg::RESET;

  core_ctrl uut (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference models
  ////////////////////////////////////////////////////////////////////////////
  // next control state from the current inputs
  function automatic ctrl_pkg::ctrl_state_e ref_next(input ctrl_pkg::ctrl_state_e st);
    ctrl_pkg::ctrl_state_e nx;
    logic jump;
    logic ret;
    nx   = st;
    jump = (jump_in_dec_i == ctrl_pkg::BRANCH_JAL) || (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);
    ret  = mret_insn_i || uret_insn_i;
    case (st)
      ctrl_pkg::RESET:       if (fetch_enable_i) nx = ctrl_pkg::BOOT_SET;
      ctrl_pkg::BOOT_SET:    nx = ctrl_pkg::FIRST_FETCH;
      ctrl_pkg::SLEEP:       if (fetch_enable_i || int_req_i || ext_req_i) nx = ctrl_pkg::FIRST_FETCH;
      ctrl_pkg::FIRST_FETCH: if (id_ready_i) nx = ctrl_pkg::DECODE;
      ctrl_pkg::FLUSH_EX:    if (ex_valid_i) nx = ctrl_pkg::FLUSH_WB;
      ctrl_pkg::FLUSH_WB:    nx = fetch_enable_i ? ctrl_pkg::DECODE : ctrl_pkg::SLEEP;
      ctrl_pkg::DECODE: begin
        // interrupt only when no jump or return claims the cycle
        if (instr_valid_i && !branch_taken_ex_i) begin
          if (ext_req_i || (int_req_i && !jump && !ret)) nx = ctrl_pkg::FLUSH_EX;
          if (pipe_flush_i || (ret && !fetch_enable_i)) nx = ctrl_pkg::FLUSH_EX;
        end
      end
      default: nx = ctrl_pkg::RESET;
    endcase
    return nx;
  endfunction

  function automatic hazard_pkg::stall_t ref_stall(
    input ctrl_pkg::jump_kind_e jk, input hazard_pkg::wr_en_t we,
    input hazard_pkg::reg_match_t m, input logic dreq, input logic mis,
    input logic cbusy, input logic cacc
  );
    hazard_pkg::stall_t s;
    s.load       = dreq && we.we_ex && (m.ex_a || m.ex_b || m.ex_c);
    s.csr        = cbusy && cacc;
    s.jr         = (jk == ctrl_pkg::BRANCH_JALR) &&
                   ((we.we_wb && m.wb_a) || (we.we_ex && m.ex_a) || (we.alu_we_fw && m.alu_a));
    s.misaligned = mis;
    return s;
  endfunction

  function automatic logic ref_deassert(input logic is_dec, input logic ill,
                                        input hazard_pkg::stall_t s);
    return !is_dec || ill || s.load || s.csr || s.jr;
  endfunction

  function automatic hazard_pkg::fwd_sel_t ref_fwd(
    input hazard_pkg::wr_en_t we, input hazard_pkg::reg_match_t m,
    input logic mis, input logic mc
  );
    hazard_pkg::fwd_sel_t f;
    // ALU result is newer than WB, so it takes priority
    f.a = (we.alu_we_fw && m.alu_a) ? hazard_pkg::SEL_FW_EX :
          (we.we_wb && m.wb_a) ? hazard_pkg::SEL_FW_WB : hazard_pkg::SEL_REGFILE;
    f.b = (we.alu_we_fw && m.alu_b) ? hazard_pkg::SEL_FW_EX :
          (we.we_wb && m.wb_b) ? hazard_pkg::SEL_FW_WB : hazard_pkg::SEL_REGFILE;
    f.c = (we.alu_we_fw && m.alu_c) ? hazard_pkg::SEL_FW_EX :
          (we.we_wb && m.wb_c) ? hazard_pkg::SEL_FW_WB : hazard_pkg::SEL_REGFILE;
    if (mis) begin
      f.a = hazard_pkg::SEL_FW_EX;
      f.b = hazard_pkg::SEL_REGFILE;
    end else if (mc) begin
      f.c = hazard_pkg::SEL_FW_EX;
    end
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_bit(input string name, input logic got, input logic exp, inout int errs);
    if (got !== exp) begin
      $display("ERR %s: got %h exp %h at %0t", name, got, exp, $time);
      errs++;
    end
  endtask

  task automatic check_fwd(input hazard_pkg::fwd_sel_t got, input hazard_pkg::fwd_sel_t exp,
                           inout int errs);
    if (got !== exp) begin
      $display("ERR fwd_sel_o: got %h exp %h at %0t", got, exp, $time);
      errs++;
    end
  endtask

  task automatic check_stall(input hazard_pkg::stall_t got, input hazard_pkg::stall_t exp,
                             inout int errs);
    if (got !== exp) begin
      $display("ERR stall_o: got %h exp %h at %0t", got, exp, $time);
      errs++;
    end
  endtask

  task automatic check_exc(input ctrl_pkg::exc_ctrl_t got, input ctrl_pkg::exc_ctrl_t exp,
                           inout int errs);
    if (got !== exp) begin
      $display("ERR exc_o: got %h exp %h at %0t", got, exp, $time);
      errs++;
    end
  endtask

  // mux only matters when the PC is actually set
  task automatic check_pc(input logic set_got, input ctrl_pkg::pc_mux_e mux_got,
                          input logic set_exp, input ctrl_pkg::pc_mux_e mux_exp, inout int errs);
    if (set_got !== set_exp) begin
      $display("ERR pc_set_o: got %h exp %h at %0t", set_got, set_exp, $time);
      errs++;
    end else if (set_exp && mux_got !== mux_exp) begin
      $display("ERR pc_mux_o: got %h exp %h at %0t", mux_got, mux_exp, $time);
      errs++;
    end
  endtask

  task automatic note_failure(input string what, inout int errs);
    $display("failure at %0t: %s", $time, what);
    errs++;
  endtask

  task automatic end_test(input string name, input int base);
    int errs;
    errs = dir_errs + mon_errs - base;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers, called on a rising edge
  ////////////////////////////////////////////////////////////////////////////
  // decoding valid instructions, no hazards, no requests
  task automatic quiet_inputs();
    instr_valid_i     <= 1'b1;
    id_ready_i        <= 1'b1;
    jump_in_dec_i     <= ctrl_pkg::BRANCH_NONE;
    illegal_insn_i    <= 1'b0;
    data_req_ex_i     <= 1'b0;
    data_misaligned_i <= 1'b0;
    csr_busy_i        <= 1'b0;
    csr_access_id_i   <= 1'b0;
    mult_multicycle_i <= 1'b0;
    wr_en_i           <= '0;
    match_i           <= '0;
  endtask

  // randomizes only inputs that keep the FSM in DECODE
  task automatic drive_random(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(posedge clk);
      r = $random(seed);
      instr_valid_i     <= r[0];
      illegal_insn_i    <= r[1];
      data_req_ex_i     <= r[2];
      data_misaligned_i <= r[3];
      csr_busy_i        <= r[4];
      csr_access_id_i   <= r[5];
      mult_multicycle_i <= r[6];
      id_ready_i        <= r[7];
      jump_in_dec_i     <= ctrl_pkg::jump_kind_e'(r[9:8]);
      wr_en_i           <= r[12:10];
      match_i           <= r[21:13];
    end
    @(posedge clk);
    quiet_inputs();
  endtask

  // int or ext request in decode, flush, then handler entry in FLUSH_WB
  task automatic exc_entry(input logic ext, input string name);
    ctrl_pkg::exc_ctrl_t exp;
    int base;
    int unsigned dly;
    base        = dir_errs + mon_errs;
    exp         = '0;
    exp.ack     = 1'b1;
    exp.save_id = 1'b1;
    exp.irq_ack = ext;
    @(posedge clk);
    if (ext) begin
      ext_req_i <= 1'b1;
    end else begin
      int_req_i <= 1'b1;
    end
    @(negedge clk);
    check_bit("halt_if_o", halt_if_o, 1'b1, dir_errs);
    check_bit("halt_id_o", halt_id_o, 1'b1, dir_errs);
    dly = $unsigned($random(seed)) % 8;
    repeat (dly + 1) @(posedge clk);
    ex_valid_i <= 1'b1;
    @(posedge clk);
    ex_valid_i <= 1'b0;
    @(negedge clk);
    check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_EXCEPTION, dir_errs);
    check_exc(exc_o, exp, dir_errs);
    check_bit("enable_exceptions_o", enable_exceptions_o, 1'b1, dir_errs);
    @(posedge clk);
    int_req_i <= 1'b0;
    ext_req_i <= 1'b0;
    end_test(name, base);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // state model and continuous compare
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_st <= ctrl_pkg::RESET;
    end else begin
      model_st <= ref_next(model_st);
    end
  end

  always @(negedge clk) begin : monitor
    logic idle;
    logic dec_exp;
    hazard_pkg::stall_t st_exp;
    if (rst_n) begin
      idle    = (model_st == ctrl_pkg::RESET) || (model_st == ctrl_pkg::SLEEP);
      dec_exp = (model_st == ctrl_pkg::DECODE) && instr_valid_i && !branch_taken_ex_i;
      check_bit("ctrl_busy_o", ctrl_busy_o, !idle, mon_errs);
      check_bit("instr_req_o", instr_req_o, !idle, mon_errs);
      check_bit("is_decoding_o", is_decoding_o, dec_exp, mon_errs);
      if (idle || model_st == ctrl_pkg::FLUSH_EX) begin
        check_bit("pc_set_o", pc_set_o, 1'b0, mon_errs);
      end
      // both halts held while sleeping or draining EX
      if (model_st == ctrl_pkg::SLEEP || model_st == ctrl_pkg::FLUSH_EX) begin
        check_bit("halt_if_o", halt_if_o, 1'b1, mon_errs);
        check_bit("halt_id_o", halt_id_o, 1'b1, mon_errs);
      end
      if (chk_mode == 1) begin
        st_exp = ref_stall(jump_in_dec_i, wr_en_i, match_i, data_req_ex_i,
                           data_misaligned_i, csr_busy_i, csr_access_id_i);
        check_stall(stall_o, st_exp, mon_errs);
        check_bit("deassert_we_o", deassert_we_o,
                  ref_deassert(dec_exp, illegal_insn_i, st_exp), mon_errs);
      end
      if (chk_mode == 2) begin
        check_fwd(fwd_sel_o, ref_fwd(wr_en_i, match_i, data_misaligned_i, mult_multicycle_i),
                  mon_errs);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin : main
    int n;
    int base;
    seed = 32'h4eea;
    rst_n             <= 1'b0;
    fetch_enable_i    <= 1'b0;
    ex_valid_i        <= 1'b0;
    branch_taken_ex_i <= 1'b0;
    mret_insn_i       <= 1'b0;
    uret_insn_i       <= 1'b0;
    pipe_flush_i      <= 1'b0;
    int_req_i         <= 1'b0;
    ext_req_i         <= 1'b0;
    quiet_inputs();
    instr_valid_i     <= 1'b0;
    id_ready_i        <= 1'b0;

    // reset and boot
    base = 0;
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0, dir_errs);
      check_bit("instr_req_o", instr_req_o, 1'b0, dir_errs);
      check_bit("pc_set_o", pc_set_o, 1'b0, dir_errs);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fetch_enable_i <= 1'b1;
    n = 0;
    repeat (6) begin
      @(negedge clk);
      if (pc_set_o) begin
        n++;
        check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_BOOT, dir_errs);
      end
    end
    if (n != 1) begin
      note_failure($sformatf("boot set the PC %0d times instead of once", n), dir_errs);
    end
    @(posedge clk);
    id_ready_i    <= 1'b1;
    instr_valid_i <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!is_decoding_o && n < 10);
    if (!is_decoding_o) begin
      note_failure("is_decoding_o did not rise after the first fetch", dir_errs);
    end
    end_test("reset_boot", base);

    // JAL with ID stalled sets the PC once
    base = dir_errs + mon_errs;
    @(posedge clk);
    jump_in_dec_i <= ctrl_pkg::BRANCH_JAL;
    id_ready_i    <= 1'b0;
    n = 0;
    repeat (5) begin
      @(negedge clk);
      if (pc_set_o) begin
        n++;
        check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_JUMP, dir_errs);
      end
    end
    if (n != 1) begin
      note_failure($sformatf("stalled JAL set the PC %0d times instead of once", n), dir_errs);
    end
    @(posedge clk);
    id_ready_i    <= 1'b1;
    jump_in_dec_i <= ctrl_pkg::BRANCH_NONE;
    // JALR whose operand is still written by EX
    @(posedge clk);
    jump_in_dec_i  <= ctrl_pkg::BRANCH_JALR;
    wr_en_i.we_ex  <= 1'b1;
    match_i.ex_a   <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_pc(pc_set_o, pc_mux_o, 1'b0, ctrl_pkg::PC_JUMP, dir_errs);
      check_stall(stall_o, ref_stall(jump_in_dec_i, wr_en_i, match_i, data_req_ex_i,
                                     data_misaligned_i, csr_busy_i, csr_access_id_i), dir_errs);
    end
    @(posedge clk);
    match_i <= '0;
    @(negedge clk);
    check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_JUMP, dir_errs);
    @(posedge clk);
    jump_in_dec_i <= ctrl_pkg::BRANCH_NONE;
    wr_en_i       <= '0;
    // taken branch drops the instruction in ID
    @(posedge clk);
    branch_taken_ex_i <= 1'b1;
    @(negedge clk);
    check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_BRANCH, dir_errs);
    check_bit("is_decoding_o", is_decoding_o, 1'b0, dir_errs);
    @(posedge clk);
    branch_taken_ex_i <= 1'b0;
    end_test("jump_guard", base);

    exc_entry(1'b0, "int_entry");
    exc_entry(1'b1, "ext_entry");

    // wfi style flush with fetch disabled, then wake on interrupt
    base = dir_errs + mon_errs;
    @(posedge clk);
    fetch_enable_i <= 1'b0;
    pipe_flush_i   <= 1'b1;
    ex_valid_i     <= 1'b1;
    @(posedge clk);
    pipe_flush_i   <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ctrl_busy_o && n < 10);
    if (ctrl_busy_o) begin
      note_failure("controller did not go to sleep after the flush", dir_errs);
    end
    check_bit("instr_req_o", instr_req_o, 1'b0, dir_errs);
    check_bit("halt_if_o", halt_if_o, 1'b1, dir_errs);
    check_bit("halt_id_o", halt_id_o, 1'b1, dir_errs);
    @(posedge clk);
    ex_valid_i <= 1'b0;
    int_req_i  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!pc_set_o && n < 10);
    if (!pc_set_o) begin
      note_failure("interrupt did not wake the controller", dir_errs);
    end
    check_pc(pc_set_o, pc_mux_o, 1'b1, ctrl_pkg::PC_EXCEPTION, dir_errs);
    check_exc(exc_o, '{ack: 1'b1, irq_ack: 1'b0, save_if: 1'b1, save_id: 1'b0,
                       restore_mret: 1'b0, restore_uret: 1'b0}, dir_errs);
    @(posedge clk);
    int_req_i      <= 1'b0;
    fetch_enable_i <= 1'b1;
    end_test("sleep_wake", base);

    // random hazard inputs while decoding
    base = dir_errs + mon_errs;
    chk_mode = 1;
    drive_random(HAZ_CYCLES);
    chk_mode = 0;
    end_test("hazard_random", base);

    base = dir_errs + mon_errs;
    chk_mode = 2;
    drive_random(FWD_CYCLES);
    chk_mode = 0;
    end_test("fwd_random", base);

    $display("%0d tests, %0d failed, %0d errors, %0d cycles",
             tests_run, tests_bad, dir_errs + mon_errs, cycles);
    if (tests_bad == 0 && dir_errs + mon_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
ctrl_pkg.sv
hazard_pkg.sv
ctrl_fsm.sv
hazard_unit.sv
fwd_unit.sv
core_ctrl.sv
tb_core_ctrl.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_core_ctrl
FILELIST  := list.f
OBJDIR    := obj_dir
PASS_MSG  := Simulation finished: PASS

SIM  := $(OBJDIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
